// ==== common/eth_phy_pkg.sv ====
package eth_phy_pkg;

    // ------------------------------
    // MDIO timing, in RxClk cycles
    // ------------------------------
    localparam int MDC_HALF      = 8;   // MDC low/high time
    localparam int WRITE_SETUP   = 3;   // Phase where a new bit goes out
    localparam int READ_READY    = 6;   // Phase where PHY data is sampled
    localparam int PREAMBLE_BITS = 32;  // All ones before ST
    localparam int CMD_BITS      = 32;  // ST..DATA

    // FIFO sizes
    localparam int DATA_FIFO_DEPTH = 256;   // 16-bit words
    localparam int INFO_FIFO_DEPTH = 16;    // 32-bit status words

    // ------------------------------
    // Host register map
    // ------------------------------
    localparam logic [7:0] ADDR_RX_DATA   = 8'h00;   // Read pops data FIFO
    localparam logic [7:0] ADDR_STATUS    = 8'h01;   // Write clears FIFOs
    localparam logic [7:0] ADDR_MDIO      = 8'h02;   // Write starts transaction
    localparam logic [7:0] ADDR_RX_INFO   = 8'h03;   // Read pops info FIFO
    localparam logic [7:0] ADDR_CRC_COMP  = 8'h04;
    localparam logic [7:0] ADDR_CRC_FRAME = 8'h05;

    // GMII framing bytes
    localparam logic [7:0] SFD      = 8'hD5;
    localparam logic [7:0] PRE_BYTE = 8'h55;

    // Reflected Ethernet CRC-32
    localparam logic [31:0] CRC_POLY   = 32'hEDB88320;
    localparam logic [31:0] CRC_PRESET = 32'hFFFFFFFF;

    // Clause 22 frame after the preamble, MSB goes out first
    typedef struct packed {
        logic [1:0]  st;
        logic [1:0]  op;         // 10 read, 01 write
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [1:0]  ta;
        logic [15:0] data;
    } mdio_cmd_t;

    // One per received frame
    typedef struct packed {
        logic [4:0]  pad;
        logic        crc_error;
        logic        rx_err;
        logic        preamble_error;
        logic [7:0]  first_byte;
        logic [15:0] nbytes;     // Bytes after SFD, FCS included
    } rx_info_t;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } reg_bus_t;

    typedef struct packed {
        logic       dv;
        logic       er;
        logic [7:0] d;
    } gmii_rx_t;

endpackage

// ==== gmii_rx/crc32_byte.sv ====
`timescale 1ns/1ps

module crc32_byte import eth_phy_pkg::*; (
    input  logic        RxClk,
    input  logic        rst_n,
    input  logic        init,
    input  logic        en,
    input  logic [7:0]  d,
    output logic [31:0] crc
);

    logic [31:0] crc_q;     // Running remainder
    logic [31:0] crc_nxt;

    // LSB first, one bit per loop pass
    always_comb begin
        crc_nxt = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_nxt[0] ^ d[i])
                crc_nxt = (crc_nxt >> 1) ^ CRC_POLY;
            else
                crc_nxt = crc_nxt >> 1;
        end
    end

    always_ff @(posedge RxClk) begin
        if (!rst_n)
            crc_q <= CRC_PRESET;
        else if (init)
            crc_q <= CRC_PRESET;
        else if (en)
            crc_q <= crc_nxt;
    end

    assign crc = ~crc_q;   // Final XOR

endmodule

// ==== gmii_rx/gmii_rx_parser.sv ====
`timescale 1ns/1ps

module gmii_rx_parser import eth_phy_pkg::*; (
    input  logic        RxClk,
    input  logic        rst_n,
    input  gmii_rx_t    gmii,
    output logic        data_push,
    output logic [15:0] data_word,
    output logic        info_push,
    output rx_info_t    info,
    output logic [31:0] crc_comp,
    output logic [31:0] crc_frame
);

    logic            dv_q;        // Previous dv, flags frame end
    logic            pre_done;    // Past the SFD position
    logic [3:0]      pre_cnt;     // 0x55 bytes seen, saturating
    logic            pre_err;
    logic            rx_err;      // Sticky er within frame
    logic [15:0]     nbytes;
    logic [7:0]      first_byte;
    logic [7:0]      hi_byte;     // Upper half of word being packed
    logic [3:0][7:0] dly;         // dly[3] oldest
    logic            body_byte;
    logic            frame_end;
    logic            crc_en;
    logic [31:0]     crc_now;
    logic [31:0]     fcs_rx;

    assign body_byte = gmii.dv && pre_done;
    assign frame_end = dv_q && !gmii.dv;
    assign crc_en    = body_byte && (nbytes >= 16'd4);   // Oldest byte leaves delay line
    assign fcs_rx    = {dly[0], dly[1], dly[2], dly[3]}; // First FCS byte in LSBs

    // CRC lags four bytes behind, so FCS is left out
    crc32_byte u_crc (
        .RxClk (RxClk),
        .rst_n (rst_n),
        .init  (!gmii.dv),   // Preset between frames
        .en    (crc_en),
        .d     (dly[3]),
        .crc   (crc_now)
    );

    // ------------------------------
    // Frame control
    // ------------------------------
    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            dv_q      <= 1'b0;
            pre_done  <= 1'b0;
            pre_cnt   <= 4'd0;
            pre_err   <= 1'b0;
            rx_err    <= 1'b0;
            nbytes    <= 16'd0;
            data_push <= 1'b0;
            info_push <= 1'b0;
            crc_comp  <= 32'd0;
            crc_frame <= 32'd0;
        end else begin
            dv_q      <= gmii.dv;
            data_push <= 1'b0;
            info_push <= 1'b0;
            if (gmii.dv) begin
                rx_err <= rx_err | gmii.er;
                if (!pre_done) begin
                    if (gmii.d == PRE_BYTE) begin
                        if (pre_cnt != 4'hF)
                            pre_cnt <= pre_cnt + 4'd1;
                    end else begin
                        pre_done <= 1'b1;   // First non-0x55 byte
                        pre_err  <= (gmii.d != SFD) || (pre_cnt != 4'd7);
                    end
                end else begin
                    nbytes <= nbytes + 16'd1;
                    if (nbytes[0])
                        data_push <= 1'b1;   // Second byte of a pair
                end
            end else if (dv_q) begin
                info_push <= 1'b1;
                data_push <= nbytes[0];      // Odd tail
                crc_comp  <= crc_now;
                crc_frame <= fcs_rx;
                pre_done  <= 1'b0;
                pre_cnt   <= 4'd0;
                pre_err   <= 1'b0;
                rx_err    <= 1'b0;
                nbytes    <= 16'd0;
            end
        end
    end

    // Byte payload, packing and info word
    always_ff @(posedge RxClk) begin
        if (body_byte) begin
            dly <= {dly[2:0], gmii.d};
            if (nbytes == 16'd0)
                first_byte <= gmii.d;
            if (nbytes[0])
                data_word <= {hi_byte, gmii.d};
            else
                hi_byte <= gmii.d;
        end else if (frame_end) begin
            data_word <= {hi_byte, 8'h00};   // Only pushed on odd count
            info <= '{pad:            5'd0,
                      crc_error:      (crc_now != fcs_rx),
                      rx_err:         rx_err,
                      preamble_error: !pre_done || pre_err,   // No SFD at all
                      first_byte:     first_byte,
                      nbytes:         nbytes};
        end
    end

    // One info word per frame, frames need at least one dv-low gap
    a_info_single: assert property (@(posedge RxClk) disable iff (!rst_n)
        info_push |=> !info_push);

endmodule

// ==== mdio/mdio_master.sv ====
`timescale 1ns/1ps

module mdio_master import eth_phy_pkg::*; (
    input  logic        RxClk,
    input  logic        rst_n,
    input  logic        start,
    input  mdio_cmd_t   cmd,
    output logic        busy,
    output logic [15:0] rd_data,
    output logic [4:0]  rd_reg,
    output logic        mdc,
    output logic        mdio_o,
    output logic        mdio_oe,
    input  logic        mdio_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_CMD,
        ST_READ_TA,
        ST_READ_DATA
    } state_t;

    state_t      state;
    logic [9:0]  cnt;        // Upper 6 bits frame bit, lower 4 bits phase
    logic [3:0]  phase;
    logic [5:0]  bit_idx;
    logic        bit_end;    // Last phase of a bit
    logic        is_read;
    mdio_cmd_t   cmd_q;      // Latched on start
    logic [15:0] rd_shift;

    assign phase   = cnt[3:0];
    assign bit_idx = cnt[9:4];
    assign bit_end = (phase == 4'hF);
    assign is_read = (cmd_q.op == 2'b10);
    assign busy    = (state != ST_IDLE);
    assign mdc     = (phase >= 4'(MDC_HALF));  // Low first half, high second half

    // ------------------------------
    // Frame sequencer
    // ------------------------------
    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            cnt     <= 10'd0;
            mdio_o  <= 1'b1;
            mdio_oe <= 1'b0;
            rd_data <= 16'd0;
            rd_reg  <= 5'd0;
        end else begin
            if (state != ST_IDLE)
                cnt <= cnt + 10'd1;   // Wraps to 0 at frame end
            case (state)
                ST_IDLE: begin
                    cnt    <= 10'd0;
                    mdio_o <= 1'b1;
                    if (start) begin
                        mdio_oe <= 1'b1;   // Drive from the first preamble bit
                        state   <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (phase == 4'(WRITE_SETUP))
                        mdio_o <= 1'b1;
                    if (bit_end && bit_idx == 6'(PREAMBLE_BITS - 1))
                        state <= ST_CMD;
                end
                ST_CMD: begin
                    if (phase == 4'(WRITE_SETUP))
                        mdio_o <= cmd_q[~bit_idx[4:0]];   // Bit 32 -> cmd bit 31
                    if (is_read && bit_end && bit_idx == 6'(PREAMBLE_BITS + 13))
                        state <= ST_READ_TA;              // After REGAD
                    else if (bit_end && bit_idx == 6'(PREAMBLE_BITS + CMD_BITS - 1)) begin
                        mdio_oe <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                ST_READ_TA: begin
                    if (phase == 4'(WRITE_SETUP))
                        mdio_oe <= 1'b0;   // Hand the line to the PHY
                    if (bit_end && bit_idx == 6'(PREAMBLE_BITS + 15))
                        state <= ST_READ_DATA;
                end
                ST_READ_DATA: begin
                    if (bit_end && bit_idx == 6'(PREAMBLE_BITS + CMD_BITS - 1)) begin
                        rd_data <= rd_shift;          // Last sample taken at phase 6
                        rd_reg  <= cmd_q.reg_addr;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command latch and read shifter
    always_ff @(posedge RxClk) begin
        if (state == ST_IDLE && start)
            cmd_q <= cmd;
        if (state == ST_READ_DATA && phase == 4'(READ_READY))
            rd_shift <= {rd_shift[14:0], mdio_i};   // MSB first
    end

    // PHY owns the line for all 16 data bits
    a_no_drive_in_read: assert property (@(posedge RxClk) disable iff (!rst_n)
        (state == ST_READ_DATA) |-> !mdio_oe);

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 256
) (
    input  logic             RxClk,
    input  logic             rst_n,
    input  logic             clr,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;    // Occupancy, 0..DEPTH
    logic                     do_push;
    logic                     do_pop;

    assign empty   = (count == '0);
    assign full    = (count == ($clog2(DEPTH)+1)'(DEPTH));
    assign do_push = push && !full;     // Overflow is dropped
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];       // Fall-through head

    always_ff @(posedge RxClk) begin
        if (!rst_n || clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + ($clog2(DEPTH))'(1);
            if (do_pop)
                rd_ptr <= rd_ptr + ($clog2(DEPTH))'(1);
            case ({do_push, do_pop})
                2'b10:   count <= count + ($clog2(DEPTH)+1)'(1);
                2'b01:   count <= count - ($clog2(DEPTH)+1)'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge RxClk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    // Reader must check empty first
    a_no_pop_empty: assert property (@(posedge RxClk) disable iff (!rst_n)
        pop |-> !empty);
    // Count and pointers stay in step
    a_empty_ptrs: assert property (@(posedge RxClk) disable iff (!rst_n)
        empty |-> (wr_ptr == rd_ptr));

endmodule

// ==== hdl/phy_regs.sv ====
`timescale 1ns/1ps

module phy_regs import eth_phy_pkg::*; (
    input  logic        RxClk,
    input  logic        rst_n,
    input  reg_bus_t    bus,
    output logic [31:0] rdata,
    output logic        mdio_start,
    output mdio_cmd_t   mdio_cmd,
    input  logic        mdio_busy,
    input  logic [15:0] mdio_rd_data,
    input  logic [4:0]  mdio_rd_reg,
    input  logic [15:0] data_dout,
    input  logic        data_empty,
    input  logic        data_full,
    output logic        data_pop,
    input  rx_info_t    info_dout,
    input  logic        info_empty,
    output logic        info_pop,
    input  logic [31:0] crc_comp,
    input  logic [31:0] crc_frame,
    output logic        fifo_clr
);

    logic [31:0] rd_word;       // Read mux output
    logic [31:0] status_word;
    logic [31:0] mdio_word;     // MDIO feedback

    // FIFO heads are sampled on the same edge they advance
    assign data_pop = bus.rd && (bus.addr == ADDR_RX_DATA) && !data_empty;
    assign info_pop = bus.rd && (bus.addr == ADDR_RX_INFO) && !info_empty;

    assign status_word = {25'd0, mdio_busy, data_full, data_empty, info_empty, 3'd0};
    assign mdio_word   = {mdio_busy, 10'd0, mdio_rd_reg, mdio_rd_data};

    always_comb begin
        case (bus.addr)
            ADDR_RX_DATA:   rd_word = data_empty ? 32'd0 : {16'd0, data_dout};
            ADDR_STATUS:    rd_word = status_word;
            ADDR_MDIO:      rd_word = mdio_word;
            ADDR_RX_INFO:   rd_word = info_empty ? 32'd0 : 32'(info_dout);
            ADDR_CRC_COMP:  rd_word = crc_comp;
            ADDR_CRC_FRAME: rd_word = crc_frame;
            default:        rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            rdata      <= 32'd0;
            mdio_start <= 1'b0;
            fifo_clr   <= 1'b0;
        end else begin
            mdio_start <= bus.wr && (bus.addr == ADDR_MDIO);    // One-cycle pulses
            fifo_clr   <= bus.wr && (bus.addr == ADDR_STATUS);
            if (bus.rd)
                rdata <= rd_word;
        end
    end

    // Command word travels with the start pulse
    always_ff @(posedge RxClk) begin
        if (bus.wr && bus.addr == ADDR_MDIO)
            mdio_cmd <= mdio_cmd_t'(bus.wdata);
    end

endmodule

// ==== hdl/eth_phy_if.sv ====
`timescale 1ns/1ps

module eth_phy_if import eth_phy_pkg::*; (
    input  logic        RxClk,
    input  logic        rst_n,
    input  reg_bus_t    bus,
    output logic [31:0] rdata,
    input  gmii_rx_t    gmii,
    output logic        mdc,
    output logic        mdio_o,
    output logic        mdio_oe,
    input  logic        mdio_i,
    output logic        phy_rst_n
);

    // MDIO command path
    logic        mdio_start;
    mdio_cmd_t   mdio_cmd;
    logic        mdio_busy;
    logic [15:0] mdio_rd_data;
    logic [4:0]  mdio_rd_reg;
    // Receive path
    logic        data_push, data_pop, data_empty, data_full;
    logic [15:0] data_word, data_dout;
    logic        info_push, info_pop, info_empty;
    rx_info_t    info_word, info_dout;
    logic [31:0] crc_comp, crc_frame;
    logic        fifo_clr;

    assign phy_rst_n = 1'b1;   // PHY held out of reset

    phy_regs u_regs (
        .RxClk, .rst_n, .bus, .rdata,
        .mdio_start, .mdio_cmd, .mdio_busy, .mdio_rd_data, .mdio_rd_reg,
        .data_dout, .data_empty, .data_full, .data_pop,
        .info_dout, .info_empty, .info_pop,
        .crc_comp, .crc_frame, .fifo_clr
    );

    mdio_master u_mdio (
        .RxClk, .rst_n, .start(mdio_start), .cmd(mdio_cmd), .busy(mdio_busy),
        .rd_data(mdio_rd_data), .rd_reg(mdio_rd_reg),
        .mdc, .mdio_o, .mdio_oe, .mdio_i
    );

    gmii_rx_parser u_parser (
        .RxClk, .rst_n, .gmii, .data_push, .data_word,
        .info_push, .info(info_word), .crc_comp, .crc_frame
    );

    sync_fifo #(.WIDTH(16), .DEPTH(DATA_FIFO_DEPTH)) u_data_fifo (
        .RxClk, .rst_n, .clr(fifo_clr), .push(data_push), .din(data_word),
        .pop(data_pop), .dout(data_dout), .full(data_full), .empty(data_empty)
    );

    sync_fifo #(.WIDTH($bits(rx_info_t)), .DEPTH(INFO_FIFO_DEPTH)) u_info_fifo (
        .RxClk, .rst_n, .clr(fifo_clr), .push(info_push), .din(info_word),
        .pop(info_pop), .dout(info_dout), .full(), .empty(info_empty)
    );

endmodule

// ==== sim/eth_phy_if_tb.sv ====
`timescale 1ns/1ps

module eth_phy_if_tb import eth_phy_pkg::*; ();

    typedef logic [7:0] byte_q_t[$];

    logic        RxClk = 1'b0;
    logic        rst_n;
    reg_bus_t    bus;
    logic [31:0] rdata;
    gmii_rx_t    gmii;
    logic        mdc, mdio_o, mdio_oe, phy_rst_n;
    logic        mdio_i = 1'b0;       // Driven by the PHY model

    // PHY model state
    logic [63:0] mdio_cap  = '0;      // Wire bit 0 lands in bit 63
    logic [63:0] oe_cap    = '0;      // mdio_oe at each rising mdc
    logic [15:0] rd_val    = '0;
    int          rise_cnt  = 64;      // Rising mdc edges in current frame
    int          cyc       = 0;
    int          last_rise = 0;
    int          mdc_gap   = 16;      // Any gap other than 16 clocks
    logic        mdc_q     = 1'b0;
    logic        oe_q      = 1'b0;

    eth_phy_if UUT (
        .RxClk, .rst_n, .bus, .rdata, .gmii,
        .mdc, .mdio_o, .mdio_oe, .mdio_i, .phy_rst_n
    );

    always #20 RxClk = ~RxClk;   // 40 ns period

    // ------------------------------
    // PHY model, sees mdc edges half a clock late
    // ------------------------------
    always @(negedge RxClk) begin
        cyc = cyc + 1;
        if (mdio_oe === 1'b1 && !oe_q) begin   // New frame starts driving
            rise_cnt = 0;
            mdc_gap  = 16;
        end
        if (mdc === 1'b1 && !mdc_q && rise_cnt < 64) begin
            if (rise_cnt > 0 && cyc - last_rise != 16)
                mdc_gap = cyc - last_rise;
            last_rise = cyc;
            mdio_cap[6'(63 - rise_cnt)] = mdio_o;
            oe_cap[6'(63 - rise_cnt)]   = mdio_oe;
            rise_cnt = rise_cnt + 1;
        end
        // Read data goes out on falling mdc, bits 48..63 of the frame
        if (mdc === 1'b0 && mdc_q && rise_cnt >= 48 && rise_cnt < 64
                && mdio_cap[29:28] == 2'b10) begin
            rd_val = 16'hA500 ^ {11'd0, mdio_cap[22:18]};
            mdio_i = rd_val[4'(63 - rise_cnt)];   // MSB first
        end
        mdc_q = (mdc === 1'b1);
        oe_q  = (mdio_oe === 1'b1);
    end

    // ------------------------------
    // Error reporting
    // ------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_on_error($sformatf("Fail at %0d ns: %s expected 0x%08h, got 0x%08h",
                                $time, name, exp, act));
    endtask

    task automatic report_timeout(input string what);
        stop_on_error($sformatf("Timeout at %0d ns while waiting for %s", $time, what));
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act == exp) else report_mismatch(name, exp, act);
    endtask

    // ------------------------------
    // Host bus, all changes on falling edge
    // ------------------------------
    task automatic idle_cycles(input int n);
        bus = '0;
        repeat (n) @(negedge RxClk);
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        bus = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(negedge RxClk);
        bus = '0;
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        bus = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'd0};
        @(negedge RxClk);
        bus  = '0;
        data = rdata;   // Registered, one cycle after the strobe
    endtask

    task automatic wait_mdio_done();
        logic [31:0] word;
        int          i;
        word = 32'd0;
        for (i = 0; i < 8 && !word[31]; i++)
            reg_read(ADDR_MDIO, word);
        if (!word[31])
            report_timeout("MDIO busy to rise");
        for (i = 0; i < 1100 && word[31]; i++)
            reg_read(ADDR_MDIO, word);
        if (word[31])
            report_timeout("MDIO busy to clear");
    endtask

    task automatic wait_info_ready();
        logic [31:0] word;
        int          i;
        word = 32'h8;
        for (i = 0; i < 10 && word[3]; i++)
            reg_read(ADDR_STATUS, word);   // Bit 3 is info_empty
        if (word[3])
            report_timeout("an info word after frame end");
    endtask

    // ------------------------------
    // GMII frame helpers
    // ------------------------------
    // Reflected CRC-32, LSB of each byte first
    function automatic logic [31:0] fcs_of(input byte_q_t body);
        logic [31:0] r;
        r = 32'hFFFF_FFFF;
        foreach (body[i]) begin
            r = r ^ {24'd0, body[i]};
            for (int b = 0; b < 8; b++)
                r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
        end
        return ~r;
    endfunction

    function automatic byte_q_t with_fcs(input byte_q_t body, input logic [31:0] fcs);
        byte_q_t f;
        f = body;
        for (int k = 0; k < 4; k++)
            f.push_back(8'(fcs >> (8 * k)));   // Low byte on the wire first
        return f;
    endfunction

    function automatic byte_q_t random_body(input int len);
        byte_q_t q;
        for (int i = 0; i < len; i++)
            q.push_back(8'($urandom));
        return q;
    endfunction

    task automatic drive_byte(input logic [7:0] b, input logic er);
        gmii = '{dv: 1'b1, er: er, d: b};
        @(negedge RxClk);
    endtask

    // er_at is a body index, -1 for none
    task automatic send_frame(input byte_q_t frame, input int pre_len, input int er_at);
        for (int i = 0; i < pre_len; i++)
            drive_byte(PRE_BYTE, 1'b0);
        drive_byte(SFD, 1'b0);
        foreach (frame[i])
            drive_byte(frame[i], i == er_at);
        gmii = '0;   // dv low ends the frame
    endtask

    task automatic receive_and_check(input byte_q_t frame, input logic crc_err,
                                     input logic rx_er, input logic pre_err,
                                     input logic [31:0] comp, input logic [31:0] fcs_seen);
        rx_info_t    exp_info;
        logic [31:0] word;
        logic [15:0] pair;
        int          n;
        n = frame.size();
        wait_info_ready();
        exp_info = '{pad: 5'd0, crc_error: crc_err, rx_err: rx_er,
                     preamble_error: pre_err, first_byte: frame[0], nbytes: 16'(n)};
        reg_read(ADDR_RX_INFO, word);
        expect_eq("rx_info", exp_info, word);
        for (int i = 0; i < n; i += 2) begin
            pair = {frame[i], (i + 1 < n) ? frame[i + 1] : 8'h00};   // Zero pad on odd tail
            reg_read(ADDR_RX_DATA, word);
            expect_eq("rx_data", {16'd0, pair}, word);
        end
        reg_read(ADDR_STATUS, word);
        expect_eq("status after drain", 32'h18, word);
        reg_read(ADDR_CRC_COMP, word);
        expect_eq("crc_comp", comp, word);
        reg_read(ADDR_CRC_FRAME, word);
        expect_eq("crc_frame", fcs_seen, word);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic after_reset();
        logic [31:0] word;
        expect_eq("mdc", 32'd0, 32'(mdc));
        expect_eq("mdio_oe", 32'd0, 32'(mdio_oe));
        expect_eq("phy_rst_n", 32'd1, 32'(phy_rst_n));   // PHY kept out of reset
        reg_read(ADDR_STATUS, word);
        expect_eq("status", 32'h18, word);   // Both FIFOs empty, not busy
        reg_read(ADDR_RX_DATA, word);
        expect_eq("rx_data when empty", 32'd0, word);
        reg_read(ADDR_RX_INFO, word);
        expect_eq("rx_info when empty", 32'd0, word);
    endtask

    task automatic mdio_write_frame();
        mdio_cmd_t cmd;
        cmd = '{st: 2'b01, op: 2'b01, phy_addr: 5'($urandom), reg_addr: 5'($urandom),
                ta: 2'b10, data: 16'($urandom)};
        reg_write(ADDR_MDIO, cmd);
        wait_mdio_done();
        expect_eq("MDIO preamble", 32'hFFFF_FFFF, mdio_cap[63:32]);
        expect_eq("MDIO command", cmd, mdio_cap[31:0]);
        expect_eq("mdc period", 32'd16, mdc_gap);
        expect_eq("mdio_oe", 32'd0, 32'(mdio_oe));
    endtask

    task automatic mdio_read_frame();
        mdio_cmd_t   cmd;
        logic [4:0]  ra;
        logic [31:0] word;
        ra  = 5'($urandom);
        cmd = '{st: 2'b01, op: 2'b10, phy_addr: 5'($urandom), reg_addr: ra,
                ta: 2'b00, data: 16'd0};
        reg_write(ADDR_MDIO, cmd);
        wait_mdio_done();
        expect_eq("mdio_oe in read data bits", 32'd0, {16'd0, oe_cap[15:0]});
        expect_eq("mdc period", 32'd16, mdc_gap);
        reg_read(ADDR_MDIO, word);
        expect_eq("MDIO read word", {11'd0, ra, 16'hA500 ^ {11'd0, ra}}, word);
    endtask

    task automatic good_frames();
        byte_q_t     body;
        logic [31:0] fcs;
        int          len;
        for (int k = 0; k < 6; k++) begin
            len  = 2 * int'($urandom_range(20, 3)) - (k % 2);   // Alternates even and odd
            body = random_body(len);
            fcs  = fcs_of(body);
            send_frame(with_fcs(body, fcs), 7, -1);
            receive_and_check(with_fcs(body, fcs), 1'b0, 1'b0, 1'b0, fcs, fcs);
        end
    endtask

    task automatic bad_frames();
        byte_q_t     body;
        logic [31:0] fcs;
        body = random_body(17);
        fcs  = fcs_of(body);
        // Six preamble bytes before SFD
        send_frame(with_fcs(body, fcs), 6, -1);
        receive_and_check(with_fcs(body, fcs), 1'b0, 1'b0, 1'b1, fcs, fcs);
        // Flipped top bit of last FCS byte
        send_frame(with_fcs(body, fcs ^ 32'h8000_0000), 7, -1);
        receive_and_check(with_fcs(body, fcs ^ 32'h8000_0000), 1'b1, 1'b0, 1'b0,
                          fcs, fcs ^ 32'h8000_0000);
        // er on one body byte
        send_frame(with_fcs(body, fcs), 7, 5);
        receive_and_check(with_fcs(body, fcs), 1'b0, 1'b1, 1'b0, fcs, fcs);
    endtask

    task automatic fifo_reset();
        byte_q_t     body;
        logic [31:0] word;
        body = random_body(12);
        send_frame(with_fcs(body, fcs_of(body)), 7, -1);
        wait_info_ready();
        reg_read(ADDR_STATUS, word);
        expect_eq("status with frame buffered", 32'h0, word);
        reg_write(ADDR_STATUS, 32'd0);
        idle_cycles(2);   // fifo_clr is registered
        reg_read(ADDR_STATUS, word);
        expect_eq("status after clear", 32'h18, word);
        reg_read(ADDR_RX_DATA, word);
        expect_eq("rx_data after clear", 32'd0, word);
        reg_read(ADDR_RX_INFO, word);
        expect_eq("rx_info after clear", 32'd0, word);
    endtask

    initial begin
        int seed_ret;
        bus      = '0;
        gmii     = '0;
        rst_n    = 1'b0;
        seed_ret = $urandom(32'h676c);
        repeat (10) @(negedge RxClk);
        rst_n = 1'b1;
        @(negedge RxClk);
        after_reset();
        mdio_write_frame();
        mdio_read_frame();
        good_frames();
        bad_frames();
        fifo_reset();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== eth_phy_if.f ====
common/eth_phy_pkg.sv
gmii_rx/crc32_byte.sv
gmii_rx/gmii_rx_parser.sv
mdio/mdio_master.sv
hdl/sync_fifo.sv
hdl/phy_regs.sv
hdl/eth_phy_if.sv
sim/eth_phy_if_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the eth_phy_if testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module eth_phy_if_tb \
    -f eth_phy_if.f -o Veth_phy_if_tb > build.log 2>&1 \
    && { ./obj_dir/Veth_phy_if_tb > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "Testbench failed" sim.log \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed, see build.log and sim.log"; exit 1; }
